// File: Makefile
SIM  = obj_dir/Vmem_stage_tb
SRCS = $(shell grep -v '^+' mem_stage.f)

.PHONY: run clean

$(SIM): $(SRCS) mem_stage.f
	verilator --binary --timing --assert -Wno-fatal --top-module mem_stage_tb \
		-f mem_stage.f -o Vmem_stage_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "NO ERRORS" sim.log
	! grep -q "ERRORS FOUND" sim.log

clean:
	rm -rf obj_dir sim.log

// File: mem_stage.f
source/mem_pkg.sv
source/exe_tl_latch.sv
source/dtlb.sv
source/dcache.sv
source/mem_stage_ctrl.sv
source/mem_stage.sv
verification/mem_stage_properties.sv
verification/mem_stage_tb.sv

// File: source/dcache.sv
// Direct-mapped write-through data cache with hit detection, fill and writeback record
`timescale 1ns/100ps
`default_nettype none

module dcache (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic                          kill_i,
	input  logic                          stall_i,
	input  mem_pkg::tl_bundle_t           tl_i,
	input  logic [mem_pkg::PN_BITS-1:0]   ppage_i,
	input  logic                          tlb_hit_i,
	input  logic                          fill_en_i,
	input  logic                          store_en_i,
	input  logic [31:0]                   fill_data_i,
	output logic                          hit_o,
	output logic [31:0]                   paddr_o,
	output mem_pkg::wb_bundle_t           wb_o
);

	logic [mem_pkg::LINE_COUNT-1:0] valid_q;
	logic [mem_pkg::TAG_BITS-1:0]   tag_q  [mem_pkg::LINE_COUNT];
	logic [31:0]                    data_q [mem_pkg::LINE_COUNT];

	logic [mem_pkg::INDEX_BITS-1:0] index;
	logic [mem_pkg::TAG_BITS-1:0]   tag;

	// Copy of the last translated access, kept for the fill or store after a kill
	logic [mem_pkg::INDEX_BITS-1:0] pend_index_q;
	logic [mem_pkg::TAG_BITS-1:0]   pend_tag_q;
	logic [31:0]                    pend_data_q;
	logic                           pend_hit_q;

	logic        tl_valid;
	logic        tlb_miss;
	logic        retire;
	logic [31:0] exc_bits;
	logic [31:0] load_data;

	assign paddr_o = {ppage_i, tl_i.cache_addr[mem_pkg::PAGE_BITS-1:0]};
	assign index   = paddr_o[2 +: mem_pkg::INDEX_BITS];
	assign tag     = paddr_o[2 + mem_pkg::INDEX_BITS +: mem_pkg::TAG_BITS];

	assign hit_o = tl_i.cache_enable && tlb_hit_i && valid_q[index] && tag_q[index] == tag;

	// An all-zero instruction word is the bubble left by reset or kill
	assign tl_valid = (tl_i.instruction.i_fmt.opcode != 7'd0);
	assign tlb_miss = tl_i.cache_enable && !tlb_hit_i;
	assign retire   = tl_valid && !stall_i && !kill_i;

	// A missed load has been filled by the time it retires
	assign load_data = (tl_i.cache_enable && !tl_i.store && tlb_hit_i) ? data_q[index] : 32'd0;

	always_comb begin
		exc_bits = tl_i.exc_bits;
		exc_bits[mem_pkg::EXC_TLB_MISS] = tl_i.exc_bits[mem_pkg::EXC_TLB_MISS] | tlb_miss;
	end

	always_ff @(posedge clk_i) begin
		if (tl_i.cache_enable && tlb_hit_i) begin
			pend_index_q <= index;
			pend_tag_q   <= tag;
			pend_data_q  <= tl_i.store_data;
			pend_hit_q   <= hit_o;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= '0;
		end else if (fill_en_i) begin
			valid_q[pend_index_q] <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (fill_en_i) begin
			tag_q[pend_index_q]  <= pend_tag_q;
			data_q[pend_index_q] <= fill_data_i;
		end else if (store_en_i && pend_hit_q) begin
			data_q[pend_index_q] <= pend_data_q; // No allocation on a store miss
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb_o.valid <= 1'b0;
		end else begin
			wb_o.valid <= retire;
		end
		if (retire) begin
			wb_o.write_addr       <= tl_i.write_addr;
			wb_o.int_write_enable <= tl_i.int_write_enable && !tlb_miss;
			wb_o.data             <= load_data;
			wb_o.exc_bits         <= exc_bits;
			wb_o.pc               <= tl_i.pc;
		end
	end

endmodule

`default_nettype wire

// File: source/dtlb.sv
// Fully associative data TLB with round-robin fill and combinational lookup
`timescale 1ns/100ps
`default_nettype none

module dtlb #(
	parameter int TLB_ENTRIES = 8
) (
	input  logic                             clk_i,
	input  logic                             rst_i,
	input  mem_pkg::tl_bundle_t              tl_i,
	output logic [mem_pkg::PN_BITS-1:0]      ppage_o,
	output logic                             hit_o
);

	localparam int PTR_BITS = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

	logic [TLB_ENTRIES-1:0]     valid_q;
	logic [mem_pkg::PN_BITS-1:0] vpage_q [TLB_ENTRIES];
	logic [mem_pkg::PN_BITS-1:0] ppage_q [TLB_ENTRIES];
	logic [PTR_BITS-1:0]        ptr_q;

	logic [mem_pkg::PN_BITS-1:0] look_vpage;
	logic [mem_pkg::PN_BITS-1:0] wr_vpage;
	logic [mem_pkg::PN_BITS-1:0] wr_ppage;
	logic                        wr_en;
	logic                        wr_match;
	logic [PTR_BITS-1:0]         wr_idx;

	assign look_vpage = tl_i.cache_addr[31:mem_pkg::PAGE_BITS];
	assign wr_vpage   = tl_i.read_data_a[31:mem_pkg::PAGE_BITS];
	assign wr_ppage   = tl_i.read_data_b[31:mem_pkg::PAGE_BITS];
	assign wr_en      = tl_i.tlbwrite && !tl_i.idtlb; // Instruction TLB writes are dropped

	always_comb begin
		hit_o   = 1'b0;
		ppage_o = '0;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			if (valid_q[i] && vpage_q[i] == look_vpage) begin
				hit_o   = 1'b1;
				ppage_o = ppage_q[i];
			end
		end
	end

	// A page that is already mapped is rewritten in place
	always_comb begin
		wr_match = 1'b0;
		wr_idx   = ptr_q;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			if (valid_q[i] && vpage_q[i] == wr_vpage) begin
				wr_match = 1'b1;
				wr_idx   = PTR_BITS'(i);
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= '0;
			ptr_q   <= '0;
		end else if (wr_en) begin
			valid_q[wr_idx] <= 1'b1;
			if (!wr_match) begin
				ptr_q <= (ptr_q == PTR_BITS'(TLB_ENTRIES - 1)) ? '0 : ptr_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			vpage_q[wr_idx] <= wr_vpage;
			ppage_q[wr_idx] <= wr_ppage;
		end
	end

endmodule

`default_nettype wire

// File: source/exe_tl_latch.sv
// Execute to translate pipeline register with memory operation classification
`timescale 1ns/100ps
`default_nettype none

module exe_tl_latch (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                kill_i,
	input  logic                stall_i,
	input  mem_pkg::exe_bundle_t exe_i,
	output mem_pkg::tl_bundle_t  tl_o
);

	logic is_load;
	logic is_store;
	logic is_tlbw;

	assign is_load  = (exe_i.instruction.i_fmt.opcode == mem_pkg::OP_LOAD);
	assign is_store = (exe_i.instruction.s_fmt.opcode == mem_pkg::OP_STORE);
	// Only the custom-0 encoding may carry a TLB write
	assign is_tlbw  = exe_i.tlbwrite && (exe_i.instruction.i_fmt.opcode == mem_pkg::OP_TLBW);

	always_ff @(posedge clk_i) begin
		if (rst_i || kill_i) begin
			tl_o <= '0;
		end else if (!stall_i) begin
			tl_o.cache_enable     <= is_load || is_store;
			tl_o.store            <= is_store;
			tl_o.cache_addr       <= exe_i.cache_addr;
			tl_o.write_addr       <= exe_i.write_addr;
			tl_o.int_write_enable <= is_load ? exe_i.int_write_enable : 1'b0; // Stores write no register
			tl_o.store_data       <= exe_i.store_data;
			tl_o.tlbwrite         <= is_tlbw;
			tl_o.idtlb            <= exe_i.idtlb;
			tl_o.read_data_a      <= exe_i.read_data_a;
			tl_o.read_data_b      <= exe_i.read_data_b;
			tl_o.exc_bits         <= exe_i.exc_bits;
			tl_o.instruction      <= exe_i.instruction;
			tl_o.pc               <= exe_i.pc;
		end
	end

endmodule

`default_nettype wire

// File: source/mem_pkg.sv
// Memory stage package with instruction formats, stage bundles, opcodes and cache geometry
`default_nettype none

package mem_pkg;

	localparam logic [6:0] OP_LOAD  = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_TLBW  = 7'b0001011; // custom-0

	localparam int PAGE_BITS = 12;
	localparam int PN_BITS   = 32 - PAGE_BITS; // Virtual and physical page number width

	// The cache covers a 24-bit physical space of one-word lines
	localparam int LINE_COUNT = 16;
	localparam int INDEX_BITS = 4;
	localparam int TAG_BITS   = 18;

	localparam int EXC_TLB_MISS = 13;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// Loads read the word as I-type, stores as S-type
	typedef union packed {
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
	} rv_instr_u;

	typedef struct packed {
		logic [31:0] cache_addr;
		logic [4:0]  write_addr;
		logic        int_write_enable;
		logic [31:0] store_data;
		logic        tlbwrite;
		logic        idtlb;
		logic [31:0] read_data_a;
		logic [31:0] read_data_b;
		logic [31:0] exc_bits;
		rv_instr_u   instruction;
		logic [31:0] pc;
	} exe_bundle_t;

	typedef struct packed {
		logic        cache_enable;
		logic        store;
		logic [31:0] cache_addr;
		logic [4:0]  write_addr;
		logic        int_write_enable;
		logic [31:0] store_data;
		logic        tlbwrite;
		logic        idtlb;
		logic [31:0] read_data_a;
		logic [31:0] read_data_b;
		logic [31:0] exc_bits;
		rv_instr_u   instruction;
		logic [31:0] pc;
	} tl_bundle_t;

	typedef struct packed {
		logic        valid;
		logic [4:0]  write_addr;
		logic        int_write_enable;
		logic [31:0] data;
		logic [31:0] exc_bits;
		logic [31:0] pc;
	} wb_bundle_t;

	typedef struct packed {
		logic        req;
		logic        we;
		logic [31:0] addr;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

// File: source/mem_stage.sv
// Memory stage top level joining the latch, data TLB, data cache and controller
`timescale 1ns/100ps
`default_nettype none

module mem_stage #(
	parameter int TLB_ENTRIES = 8
) (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 kill_i,
	input  mem_pkg::exe_bundle_t exe_i,
	input  mem_pkg::mem_rsp_t    mem_rsp_i,
	output mem_pkg::wb_bundle_t  wb_o,
	output logic                 stall_core_o,
	output mem_pkg::mem_req_t    mem_req_o
);

	mem_pkg::tl_bundle_t         tl;
	logic [mem_pkg::PN_BITS-1:0] ppage;
	logic                        tlb_hit;
	logic                        cache_hit;
	logic [31:0]                 paddr;
	logic                        fill_en;
	logic                        store_en;

	exe_tl_latch exe_tl_latch_inst (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.kill_i  (kill_i),
		.stall_i (stall_core_o),
		.exe_i   (exe_i),
		.tl_o    (tl)
	);

	dtlb #(
		.TLB_ENTRIES (TLB_ENTRIES)
	) dtlb_inst (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.tl_i    (tl),
		.ppage_o (ppage),
		.hit_o   (tlb_hit)
	);

	dcache dcache_inst (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.kill_i      (kill_i),
		.stall_i     (stall_core_o),
		.tl_i        (tl),
		.ppage_i     (ppage),
		.tlb_hit_i   (tlb_hit),
		.fill_en_i   (fill_en),
		.store_en_i  (store_en),
		.fill_data_i (mem_rsp_i.rdata),
		.hit_o       (cache_hit),
		.paddr_o     (paddr),
		.wb_o        (wb_o)
	);

	mem_stage_ctrl mem_stage_ctrl_inst (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.tl_i        (tl),
		.tlb_hit_i   (tlb_hit),
		.cache_hit_i (cache_hit),
		.paddr_i     (paddr),
		.mem_rsp_i   (mem_rsp_i),
		.mem_req_o   (mem_req_o),
		.fill_en_o   (fill_en),
		.store_en_o  (store_en),
		.stall_o     (stall_core_o)
	);

endmodule

`default_nettype wire

// File: source/mem_stage_ctrl.sv
// Miss and store sequencer with the four-phase memory handshake and the core stall
`timescale 1ns/100ps
`default_nettype none

module mem_stage_ctrl (
	input  logic                clk_i,
	input  logic                rst_i,
	input  mem_pkg::tl_bundle_t tl_i,
	input  logic                tlb_hit_i,
	input  logic                cache_hit_i,
	input  logic [31:0]         paddr_i,
	input  mem_pkg::mem_rsp_t   mem_rsp_i,
	output mem_pkg::mem_req_t   mem_req_o,
	output logic                fill_en_o,
	output logic                store_en_o,
	output logic                stall_o
);

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		DROP
	} state_t;

	state_t state_q;

	logic start_rd;
	logic start_wr;
	logic ack_in_req;

	// Only translated accesses go to memory
	assign start_rd = tl_i.cache_enable && !tl_i.store && tlb_hit_i && !cache_hit_i;
	assign start_wr = tl_i.cache_enable && tl_i.store && tlb_hit_i;

	assign ack_in_req = (state_q == REQ) && mem_rsp_i.ack;
	assign fill_en_o  = ack_in_req && !mem_req_o.we;
	assign store_en_o = ack_in_req && mem_req_o.we;

	always_comb begin
		case (state_q)
			IDLE:    stall_o = start_rd || start_wr;
			REQ:     stall_o = 1'b1;
			DROP:    stall_o = mem_rsp_i.ack; // Released once memory lets go of ack
			default: stall_o = 1'b1;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q       <= IDLE;
			mem_req_o.req <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (start_rd || start_wr) begin
						mem_req_o.req <= 1'b1;
						state_q       <= REQ;
					end
				end
				REQ: begin
					if (mem_rsp_i.ack) begin
						mem_req_o.req <= 1'b0;
						state_q       <= DROP;
					end
				end
				DROP: begin
					if (!mem_rsp_i.ack) begin
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Address and data stay put for the whole handshake, even after a kill
	always_ff @(posedge clk_i) begin
		if (state_q == IDLE && (start_rd || start_wr)) begin
			mem_req_o.we    <= start_wr;
			mem_req_o.addr  <= paddr_i;
			mem_req_o.wdata <= tl_i.store_data;
		end
	end

endmodule

`default_nettype wire

// File: verification/mem_stage_properties.sv
// Concurrent assertions on the memory handshake and the core stall of the controller
`timescale 1ns/100ps
`default_nettype none

module mem_stage_properties (
	input logic                clk_i,
	input logic                rst_i,
	input mem_pkg::tl_bundle_t tl_i,
	input logic                tlb_hit_i,
	input mem_pkg::mem_req_t   mem_req_o,
	input mem_pkg::mem_rsp_t   mem_rsp_i,
	input logic                stall_o
);

	// Request is held until memory acknowledges
	req_held: assert property (@(posedge clk_i) disable iff (rst_i)
		mem_req_o.req && !mem_rsp_i.ack |=> mem_req_o.req)
		else $error("req dropped before ack");

	addr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
		mem_req_o.req && $past(mem_req_o.req) |-> $stable(mem_req_o.addr))
		else $error("addr changed while req was high");

	// Phase four must finish before a new request
	no_req_on_ack: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(mem_req_o.req) |-> !$past(mem_rsp_i.ack))
		else $error("req rose while ack was high");

	stall_has_cause: assert property (@(posedge clk_i) disable iff (rst_i)
		stall_o |-> (tl_i.cache_enable && tlb_hit_i) || mem_req_o.req || mem_rsp_i.ack)
		else $error("stall without a memory operation");

endmodule

bind mem_stage_ctrl mem_stage_properties mem_stage_properties_inst (
	.clk_i     (clk_i),
	.rst_i     (rst_i),
	.tl_i      (tl_i),
	.tlb_hit_i (tlb_hit_i),
	.mem_req_o (mem_req_o),
	.mem_rsp_i (mem_rsp_i),
	.stall_o   (stall_o)
);

`default_nettype wire

// File: verification/mem_stage_tb.sv
// Testbench for mem_stage with memory model, shadow reference, checkers and watchdog
`timescale 1ns/100ps
`default_nettype none

module mem_stage_tb;

	localparam int OP_COUNT = 240; // Upper bound on operations in all tests
	localparam logic [19:0] VP_BASE = 20'h00040;
	localparam logic [6:0] OP_ALU = 7'b0110011;

	logic                 clk_i;
	logic                 rst_i;
	logic                 kill_i;
	mem_pkg::exe_bundle_t exe_i;
	mem_pkg::mem_rsp_t    mem_rsp_i;
	mem_pkg::wb_bundle_t  wb_o;
	logic                 stall_core_o;
	mem_pkg::mem_req_t    mem_req_o;

	integer seed = 88470;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_start_errors;
	int req_count = 0;
	int req_before;
	logic [31:0] pc_next = 32'h1000;
	logic [31:0] rnd;
	logic [31:0] rnd_delay;
	logic [31:0] addr;
	logic [7:0]  model_idx;
	int delay;
	logic [31:0] rand_addr;
	mem_pkg::exe_bundle_t rand_op;

	// Model memory is what the DUT wrote, shadow memory is what the stimulus expects
	logic [31:0] model_mem [256];
	logic        model_written [256];
	logic [31:0] sh_mem [256];
	logic        sh_written [256];
	logic        sh_valid [4];
	logic [19:0] sh_ppage [4];

	mem_pkg::wb_bundle_t exp_wb_q [$];
	mem_pkg::mem_req_t   exp_wr_q [$];

	mem_stage #(
		.TLB_ENTRIES (8)
	) mem_stage_inst (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.kill_i       (kill_i),
		.exe_i        (exe_i),
		.mem_rsp_i    (mem_rsp_i),
		.wb_o         (wb_o),
		.stall_core_o (stall_core_o),
		.mem_req_o    (mem_req_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	initial begin
		#(OP_COUNT * 20 * 10);
		$display("Watchdog timeout, the tests did not finish in time");
		$display("ERRORS FOUND");
		$finish;
	end

	function automatic logic [7:0] word_index(input logic [31:0] a);
		return {a[13:12], a[7:2]};
	endfunction

	// Returns {hit, ppage} from the shadow page map
	function automatic logic [20:0] shadow_lookup(input logic [19:0] vpage);
		logic [20:0] r;
		r = '0;
		for (int k = 0; k < 4; k++) begin
			if (sh_valid[k] && vpage == VP_BASE + 20'(k)) r = {1'b1, sh_ppage[k]};
		end
		return r;
	endfunction

	function automatic mem_pkg::wb_bundle_t ref_access(input mem_pkg::exe_bundle_t e);
		mem_pkg::wb_bundle_t w;
		logic [20:0] tr;
		logic [31:0] pa;
		logic is_load;
		logic is_store;
		w = '0;
		is_load  = e.instruction.i_fmt.opcode == mem_pkg::OP_LOAD;
		is_store = e.instruction.s_fmt.opcode == mem_pkg::OP_STORE;
		tr = shadow_lookup(e.cache_addr[31:12]);
		pa = {tr[19:0], e.cache_addr[11:0]};
		w.valid      = 1'b1;
		w.write_addr = e.write_addr;
		w.pc         = e.pc;
		w.exc_bits   = e.exc_bits;
		if ((is_load || is_store) && !tr[20]) w.exc_bits[mem_pkg::EXC_TLB_MISS] = 1'b1;
		if (is_load && tr[20]) begin
			w.int_write_enable = e.int_write_enable;
			w.data = sh_written[word_index(pa)] ? sh_mem[word_index(pa)] : ~pa;
		end
		return w;
	endfunction

	task automatic check_wb(input mem_pkg::wb_bundle_t exp, input mem_pkg::wb_bundle_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t: wb_o expected %h got %h", $time, exp, act);
		end
	endtask

	task automatic check_mem_write(input mem_pkg::mem_req_t exp, input mem_pkg::mem_req_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t: mem_req_o expected %h got %h", $time, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic fail(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	function automatic mem_pkg::exe_bundle_t make_op(input logic [6:0] opcode,
		input logic [31:0] a, input logic [31:0] b, input logic [31:0] data);
		mem_pkg::exe_bundle_t e;
		e = '0;
		e.instruction.i_fmt.opcode = opcode;
		e.instruction.i_fmt.rd     = 5'd7;
		e.write_addr       = 5'd7;
		e.int_write_enable = 1'b1; // Must survive only for loads
		e.cache_addr       = a;
		e.read_data_a      = a;
		e.read_data_b      = b;
		e.store_data       = data;
		e.tlbwrite         = (opcode == mem_pkg::OP_TLBW);
		return e;
	endfunction

	function automatic logic [31:0] vaddr(input int page, input logic [5:0] word);
		return {VP_BASE + 20'(page), 4'h0, word, 2'b00};
	endfunction

	task automatic run_op(input mem_pkg::exe_bundle_t e_in);
		mem_pkg::exe_bundle_t e;
		mem_pkg::mem_req_t wr;
		logic [20:0] tr;
		int cycles;
		e = e_in;
		e.pc = pc_next;
		pc_next = pc_next + 4;
		exp_wb_q.push_back(ref_access(e));
		tr = shadow_lookup(e.cache_addr[31:12]);
		if (e.instruction.s_fmt.opcode == mem_pkg::OP_STORE && tr[20]) begin
			wr = {1'b1, 1'b1, tr[19:0], e.cache_addr[11:0], e.store_data};
			exp_wr_q.push_back(wr);
			sh_mem[word_index(wr.addr)] = e.store_data;
			sh_written[word_index(wr.addr)] = 1'b1;
		end
		if (e.tlbwrite && !e.idtlb) begin
			sh_valid[e.read_data_a[13:12]] = 1'b1;
			sh_ppage[e.read_data_a[13:12]] = e.read_data_b[31:12];
		end
		@(posedge clk_i);
		#1 exe_i = e;
		@(posedge clk_i);
		#1 exe_i = '0;
		cycles = 0;
		while (exp_wb_q.size() != 0 && cycles < 40) begin
			@(posedge clk_i);
			cycles++;
		end
		if (exp_wb_q.size() != 0) begin
			fail($sformatf("no writeback record arrived for pc %h", e.pc));
			exp_wb_q.delete();
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("Test %s finished with %0d errors", name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	always @(negedge clk_i) begin
		if (!rst_i && wb_o.valid) begin
			if (exp_wb_q.size() == 0) fail("writeback record appeared that was not expected");
			else check_wb(exp_wb_q.pop_front(), wb_o);
		end
	end

	// Memory model answering the four-phase handshake
	initial begin
		mem_rsp_i = '0;
		for (int i = 0; i < 256; i++) begin
			model_written[i] = 1'b0;
			sh_written[i] = 1'b0;
		end
		forever begin
			@(negedge clk_i);
			if (mem_req_o.req && !mem_rsp_i.ack) begin
				req_count++;
				addr = mem_req_o.addr;
				model_idx = word_index(addr);
				if (mem_req_o.we) begin
					if (exp_wr_q.size() == 0) fail("memory write that was not expected");
					else check_mem_write(exp_wr_q.pop_front(), mem_req_o);
					model_mem[model_idx] = mem_req_o.wdata;
					model_written[model_idx] = 1'b1;
				end
				rnd_delay = $random(seed);
				delay = 1 + int'(rnd_delay[1:0]);
				repeat (delay) @(posedge clk_i);
				#1;
				mem_rsp_i.ack = 1'b1;
				mem_rsp_i.rdata = model_written[model_idx] ? model_mem[model_idx] : ~addr;
				@(negedge clk_i);
				while (mem_req_o.req) @(negedge clk_i);
				@(posedge clk_i);
				#1 mem_rsp_i = '0;
			end
		end
	end

	initial begin
		rst_i = 1'b1;
		kill_i = 1'b0;
		exe_i = '0;
		for (int k = 0; k < 4; k++) sh_valid[k] = 1'b0;
		test_start_errors = 0;
		repeat (3) @(posedge clk_i);
		#1 rst_i = 1'b0;

		repeat (4) begin
			@(negedge clk_i);
			check_flag("wb_o.valid", 1'b0, wb_o.valid);
			check_flag("stall_core_o", 1'b0, stall_core_o);
			check_flag("mem_req_o.req", 1'b0, mem_req_o.req);
		end
		end_test("reset");

		run_op(make_op(mem_pkg::OP_TLBW, vaddr(0, 0), 32'h0000_2000, 0));
		req_before = req_count;
		run_op(make_op(mem_pkg::OP_LOAD, vaddr(0, 6'd5), 0, 0));
		check_flag("first load handshake", 1'b1, req_count == req_before + 1);
		req_before = req_count;
		run_op(make_op(mem_pkg::OP_LOAD, vaddr(0, 6'd5), 0, 0));
		check_flag("repeat load handshake", 1'b0, req_count != req_before);
		end_test("tlb_write_load");

		run_op(make_op(mem_pkg::OP_STORE, vaddr(0, 6'd5), 0, 32'hcafe_0005));
		run_op(make_op(mem_pkg::OP_STORE, vaddr(0, 6'd9), 0, 32'h1234_5678));
		run_op(make_op(mem_pkg::OP_LOAD, vaddr(0, 6'd5), 0, 0));
		run_op(make_op(mem_pkg::OP_LOAD, vaddr(0, 6'd9), 0, 0));
		check_flag("write queue drained", 1'b1, exp_wr_q.size() == 0);
		end_test("store_write_through");

		req_before = req_count;
		run_op(make_op(mem_pkg::OP_LOAD, {20'h00077, 12'h010}, 0, 0));
		check_flag("tlb miss handshake", 1'b0, req_count != req_before);
		end_test("tlb_miss");

		run_op(make_op(OP_ALU, 32'h55, 32'h66, 0));
		@(posedge clk_i);
		#1 exe_i = make_op(OP_ALU, 32'h1, 32'h2, 0);
		@(posedge clk_i);
		#1 exe_i = '0;
		kill_i = 1'b1;
		@(posedge clk_i);
		#1 kill_i = 1'b0;
		repeat (4) @(posedge clk_i);
		end_test("alu_kill");

		for (int k = 0; k < 4; k++) begin
			run_op(make_op(mem_pkg::OP_TLBW, vaddr(k, 0), {20'(3 - k), 12'h0}, 0));
		end
		for (int n = 0; n < 200; n++) begin
			rnd = $random(seed);
			if (rnd[1:0] == 2'd0) begin
				rand_op = make_op(mem_pkg::OP_TLBW, vaddr(int'(rnd[3:2]), 0),
					{18'h0, rnd[11:10], 12'h0}, 0);
				rand_op.idtlb = (rnd[17:16] == 2'd0);
				run_op(rand_op);
			end else begin
				rand_addr = (rnd[15:12] == 4'd0) ? {20'h00077, 12'h020}
					: vaddr(int'(rnd[3:2]), rnd[9:4]);
				if (rnd[1:0] == 2'd3) begin
					run_op(make_op(mem_pkg::OP_STORE, rand_addr, 0, $random(seed)));
				end else begin
					run_op(make_op(mem_pkg::OP_LOAD, rand_addr, 0, 0));
				end
			end
		end
		check_flag("write queue drained", 1'b1, exp_wr_q.size() == 0);
		end_test("random_mix");

		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire
